//--- htu_pkg.sv
package htu_pkg;

  localparam int ADDR_W = 32;

  // Tag covers address bits 31 to 10
  localparam int TAG_W = 22;

  // Address bit that picks the half-line
  localparam int OFFSET_BIT = 9;

  typedef enum logic [1:0] {
    OP_READ       = 2'd0,
    OP_WRITE      = 2'd1,
    OP_FLUSH      = 2'd2,
    OP_INVALIDATE = 2'd3
  } htu_op_e;

  typedef enum logic [1:0] {
    ST_INVALID = 2'd0,
    ST_CLEAN   = 2'd1,
    ST_DIRTY   = 2'd2
  } htu_state_e;

  typedef logic [TAG_W-1:0] htu_tag_t;

  // One decoded request, 25 bits
  typedef struct packed {
    htu_op_e  op;
    htu_tag_t tag;
    logic     offset;
  } htu_req_t;

endpackage

//--- htu_req_if.sv
`timescale 1ns/1ps

interface htu_req_if;

  import htu_pkg::*;

  logic     req_valid;
  htu_req_t req;
  logic     req_pop;

  modport fifo_side (
    output req_valid,
    output req,
    input  req_pop
  );

  modport set_side (
    input  req_valid,
    input  req,
    output req_pop
  );

endinterface

//--- htu_offset.sv
`timescale 1ns/1ps

module htu_offset (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                offset_hit_i,
  input  logic                op_is_read_i,
  input  logic                op_is_write_i,
  input  logic                op_is_flush_i,
  input  logic                op_is_invalidate_i,
  input  logic                cacheline_hit_i,
  input  logic                cacheline_allocate_i,
  output htu_pkg::htu_state_e offset_status_o
);

  import htu_pkg::*;

  htu_state_e state_q;

  assign offset_status_o = state_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_INVALID;
    end else if (cacheline_allocate_i) begin
      // Only the accessed half holds data after a fill
      if (!offset_hit_i) begin
        state_q <= ST_INVALID;
      end else if (op_is_write_i) begin
        state_q <= ST_DIRTY;
      end else begin
        state_q <= ST_CLEAN;
      end
    end else if (cacheline_hit_i) begin
      if (op_is_invalidate_i) begin
        state_q <= ST_INVALID;
      end else if (op_is_flush_i) begin
        if (state_q == ST_DIRTY) begin
          state_q <= ST_CLEAN;
        end
      end else if (offset_hit_i && op_is_write_i) begin
        state_q <= ST_DIRTY;
      end else if (offset_hit_i && op_is_read_i && state_q == ST_INVALID) begin
        state_q <= ST_CLEAN;
      end
    end
  end

endmodule

//--- htu_cacheline.sv
`timescale 1ns/1ps

module htu_cacheline (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                access_en_i,
  input  logic                op_is_read_i,
  input  logic                op_is_write_i,
  input  logic                op_is_flush_i,
  input  logic                op_is_invalidate_i,
  input  logic                access_offset1_i,
  input  htu_pkg::htu_tag_t   access_tag_i,
  input  logic                cacheline_allocate_i,
  output logic                valid_o,
  output htu_pkg::htu_tag_t   tag_o,
  output logic                hit_o,
  output htu_pkg::htu_state_e offset0_state_o,
  output htu_pkg::htu_state_e offset1_state_o
);

  import htu_pkg::*;

  logic     valid_q;
  htu_tag_t tag_q;
  logic     qual_hit;

  assign valid_o  = valid_q;
  assign tag_o    = tag_q;
  assign hit_o    = valid_q & (access_tag_i == tag_q);
  assign qual_hit = access_en_i & hit_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (cacheline_allocate_i) begin
      valid_q <= 1'b1;
    end else if (qual_hit && op_is_invalidate_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cacheline_allocate_i) begin
      tag_q <= access_tag_i;
    end
  end

  htu_offset u_offset0 (
    .clk_i               (clk_i               ),
    .rst_i               (rst_i               ),
    .offset_hit_i        (~access_offset1_i   ),
    .op_is_read_i        (op_is_read_i        ),
    .op_is_write_i       (op_is_write_i       ),
    .op_is_flush_i       (op_is_flush_i       ),
    .op_is_invalidate_i  (op_is_invalidate_i  ),
    .cacheline_hit_i     (qual_hit            ),
    .cacheline_allocate_i(cacheline_allocate_i),
    .offset_status_o     (offset0_state_o     )
  );

  htu_offset u_offset1 (
    .clk_i               (clk_i               ),
    .rst_i               (rst_i               ),
    .offset_hit_i        (access_offset1_i    ),
    .op_is_read_i        (op_is_read_i        ),
    .op_is_write_i       (op_is_write_i       ),
    .op_is_flush_i       (op_is_flush_i       ),
    .op_is_invalidate_i  (op_is_invalidate_i  ),
    .cacheline_hit_i     (qual_hit            ),
    .cacheline_allocate_i(cacheline_allocate_i),
    .offset_status_o     (offset1_state_o     )
  );

endmodule

//--- htu_set.sv
`timescale 1ns/1ps

module htu_set #(
  parameter int NUM_WAYS = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  htu_req_if.set_side                 req_if,
  output logic                        rsp_valid_o,
  output htu_pkg::htu_op_e            rsp_op_o,
  output logic                        rsp_hit_o,
  output logic [$clog2(NUM_WAYS)-1:0] rsp_way_o,
  output htu_pkg::htu_state_e         rsp_state_o,
  output logic                        rsp_writeback_o,
  output htu_pkg::htu_tag_t           rsp_wb_tag_o
);

  import htu_pkg::*;

  localparam int WAY_W = $clog2(NUM_WAYS);

  logic                s2_valid_q;
  htu_req_t            s2_req_q;
  logic [NUM_WAYS-1:0] s2_hits_q;
  logic [WAY_W-1:0]    s2_way_q;
  logic [WAY_W-1:0]    rr_q;
  logic                rsp_show_q;
  logic                rsp_off1_q;

  logic [NUM_WAYS-1:0] line_hit;
  logic [NUM_WAYS-1:0] line_valid;
  logic [NUM_WAYS-1:0] line_alloc;
  htu_tag_t            line_tag  [NUM_WAYS];
  htu_state_e          line_off0 [NUM_WAYS];
  htu_state_e          line_off1 [NUM_WAYS];

  logic [WAY_W-1:0]    hit_way;
  htu_tag_t            access_tag;
  logic                s2_hit;
  logic                s2_rd;
  logic                s2_wr;
  logic                s2_fl;
  logic                s2_inv;
  logic                s2_alloc;
  logic                victim_dirty;
  logic [WAY_W-1:0]    s2_way;

  // Stage 1 only while stage 2 is idle, so one request every two cycles
  assign req_if.req_pop = req_if.req_valid & ~s2_valid_q;

  // Head of FIFO is looked up in stage 1, the held request in stage 2
  assign access_tag = s2_valid_q ? s2_req_q.tag : req_if.req.tag;

  always_comb begin
    hit_way = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (line_hit[i]) begin
        hit_way = WAY_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s2_valid_q <= 1'b0;
    end else begin
      s2_valid_q <= req_if.req_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_if.req_pop) begin
      s2_req_q  <= req_if.req;
      s2_hits_q <= line_hit;
      s2_way_q  <= hit_way;
    end
  end

  assign s2_hit   = |s2_hits_q;
  assign s2_rd    = (s2_req_q.op == OP_READ);
  assign s2_wr    = (s2_req_q.op == OP_WRITE);
  assign s2_fl    = (s2_req_q.op == OP_FLUSH);
  assign s2_inv   = (s2_req_q.op == OP_INVALIDATE);
  assign s2_alloc = s2_valid_q & ~s2_hit & (s2_rd | s2_wr);

  assign victim_dirty = line_valid[rr_q] &
                        ((line_off0[rr_q] == ST_DIRTY) | (line_off1[rr_q] == ST_DIRTY));

  // Flush and invalidate misses report way 0
  assign s2_way = s2_hit ? s2_way_q : (s2_alloc ? rr_q : '0);

  for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
    assign line_alloc[i] = s2_alloc & (rr_q == WAY_W'(i));

    htu_cacheline u_line (
      .clk_i               (clk_i          ),
      .rst_i               (rst_i          ),
      .access_en_i         (s2_valid_q     ),
      .op_is_read_i        (s2_rd          ),
      .op_is_write_i       (s2_wr          ),
      .op_is_flush_i       (s2_fl          ),
      .op_is_invalidate_i  (s2_inv         ),
      .access_offset1_i    (s2_req_q.offset),
      .access_tag_i        (access_tag     ),
      .cacheline_allocate_i(line_alloc[i]  ),
      .valid_o             (line_valid[i]  ),
      .tag_o               (line_tag[i]    ),
      .hit_o               (line_hit[i]    ),
      .offset0_state_o     (line_off0[i]   ),
      .offset1_state_o     (line_off1[i]   )
    );
  end

  // Round-robin victim pointer
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else if (s2_alloc) begin
      rr_q <= (rr_q == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_valid_o     <= 1'b0;
      rsp_writeback_o <= 1'b0;
      rsp_show_q      <= 1'b0;
    end else begin
      rsp_valid_o     <= s2_valid_q;
      rsp_writeback_o <= s2_alloc & victim_dirty;
      if (s2_valid_q) begin
        rsp_show_q <= s2_hit | s2_alloc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s2_valid_q) begin
      rsp_op_o     <= s2_req_q.op;
      rsp_hit_o    <= s2_hit;
      rsp_way_o    <= s2_way;
      rsp_off1_q   <= s2_req_q.offset;
      rsp_wb_tag_o <= line_tag[rr_q];
    end
  end

  // Lines already hold the updated state in the response cycle
  always_comb begin
    if (!rsp_show_q) begin
      rsp_state_o = ST_INVALID;
    end else if (rsp_off1_q) begin
      rsp_state_o = line_off1[rsp_way_o];
    end else begin
      rsp_state_o = line_off0[rsp_way_o];
    end
  end

endmodule

//--- htu_cmd_decoder.sv
`timescale 1ns/1ps

module htu_cmd_decoder (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cmd_valid_i,
  input  htu_pkg::htu_op_e            cmd_op_i,
  input  logic [htu_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  logic                        full_i,
  output logic                        push_o,
  output htu_pkg::htu_req_t           req_o
);

  import htu_pkg::*;

  // A strobe that meets a full FIFO is dropped
  assign push_o = cmd_valid_i & ~full_i;

  assign req_o.op     = cmd_op_i;
  assign req_o.tag    = cmd_addr_i[ADDR_W-1 -: TAG_W];
  assign req_o.offset = cmd_addr_i[OFFSET_BIT];

endmodule

//--- htu_req_fifo.sv
`timescale 1ns/1ps

module htu_req_fifo #(
  parameter int DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              push_i,
  input  htu_pkg::htu_req_t req_i,
  output logic              full_o,
  htu_req_if.fifo_side      req_if
);

  import htu_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  htu_req_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o           = (count_q == CNT_W'(DEPTH));
  assign req_if.req_valid = (count_q != '0);
  assign req_if.req       = mem[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = req_if.req_pop & req_if.req_valid;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- htu_top.sv
`timescale 1ns/1ps

module htu_top #(
  parameter int NUM_WAYS = 4,
  parameter int DEPTH    = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cmd_valid_i,
  input  htu_pkg::htu_op_e            cmd_op_i,
  input  logic [31:0]                 cmd_addr_i,
  output logic                        cmd_full_o,
  output logic                        rsp_valid_o,
  output htu_pkg::htu_op_e            rsp_op_o,
  output logic                        rsp_hit_o,
  output logic [$clog2(NUM_WAYS)-1:0] rsp_way_o,
  output htu_pkg::htu_state_e         rsp_state_o,
  output logic                        rsp_writeback_o,
  output htu_pkg::htu_tag_t           rsp_wb_tag_o
);

  import htu_pkg::*;

  logic     dec_push;
  htu_req_t dec_req;
  logic     fifo_full;

  htu_req_if u_req_if ();

  assign cmd_full_o = fifo_full;

  htu_cmd_decoder u_decoder (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .cmd_valid_i(cmd_valid_i),
    .cmd_op_i   (cmd_op_i   ),
    .cmd_addr_i (cmd_addr_i ),
    .full_i     (fifo_full  ),
    .push_o     (dec_push   ),
    .req_o      (dec_req    )
  );

  htu_req_fifo #(
    .DEPTH(DEPTH)
  ) u_fifo (
    .clk_i (clk_i    ),
    .rst_i (rst_i    ),
    .push_i(dec_push ),
    .req_i (dec_req  ),
    .full_o(fifo_full),
    .req_if(u_req_if )
  );

  htu_set #(
    .NUM_WAYS(NUM_WAYS)
  ) u_set (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .req_if         (u_req_if       ),
    .rsp_valid_o    (rsp_valid_o    ),
    .rsp_op_o       (rsp_op_o       ),
    .rsp_hit_o      (rsp_hit_o      ),
    .rsp_way_o      (rsp_way_o      ),
    .rsp_state_o    (rsp_state_o    ),
    .rsp_writeback_o(rsp_writeback_o),
    .rsp_wb_tag_o   (rsp_wb_tag_o   )
  );

endmodule

//--- htu_checker.sv
`timescale 1ns/1ps

module htu_checker (
  input  logic clk_i,
  input  logic rst_i,
  input  logic rsp_valid_i,
  input  logic rsp_hit_i,
  input  logic rsp_writeback_i
);

  // One request every two cycles, so a response never repeats back to back
  a_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("rsp_valid_o high on two consecutive cycles");

  a_quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |-> !rsp_valid_i)
    else $error("rsp_valid_o high during reset");

  // Writebacks only come from an allocation, which is a miss
  a_wb_on_miss: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_writeback_i |-> (rsp_valid_i && !rsp_hit_i))
    else $error("rsp_writeback_o without a valid miss response");

endmodule

bind htu_top htu_checker u_checker (
  .clk_i          (clk_i          ),
  .rst_i          (rst_i          ),
  .rsp_valid_i    (rsp_valid_o    ),
  .rsp_hit_i      (rsp_hit_o      ),
  .rsp_writeback_i(rsp_writeback_o)
);

//--- htu_tb.sv
`timescale 1ns/1ps

module htu_tb;

  import htu_pkg::*;

  localparam int NUM_WAYS = 4;
  localparam int DEPTH    = 4;
  localparam int WAY_W    = $clog2(NUM_WAYS);
  localparam int TIMEOUT  = 200;
  localparam int POOL     = 6;

  typedef struct packed {
    htu_op_e    op;
    logic       hit;
    logic [WAY_W-1:0] way;
    htu_state_e state;
    logic       wb;
    htu_tag_t   wb_tag;
  } exp_rsp_t;

  logic             clk_i;
  logic             rst_i;
  logic             cmd_valid_i;
  htu_op_e          cmd_op_i;
  logic [31:0]      cmd_addr_i;
  logic             cmd_full_o;
  logic             rsp_valid_o;
  htu_op_e          rsp_op_o;
  logic             rsp_hit_o;
  logic [WAY_W-1:0] rsp_way_o;
  htu_state_e       rsp_state_o;
  logic             rsp_writeback_o;
  htu_tag_t         rsp_wb_tag_o;

  // Reference state of the bank
  logic       m_valid [NUM_WAYS];
  htu_tag_t   m_tag   [NUM_WAYS];
  htu_state_e m_st    [NUM_WAYS][2];
  int         m_rr;

  exp_rsp_t exp_q [$];
  exp_rsp_t cur_exp;
  integer   seed;
  int       test_errors;
  int       total_errors;
  int       n_checks;
  int       n_tests;
  int       n_failed;
  int       full_seen;
  logic     timed_out;

  htu_top #(
    .NUM_WAYS(NUM_WAYS),
    .DEPTH   (DEPTH   )
  ) u_dut (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .cmd_valid_i    (cmd_valid_i    ),
    .cmd_op_i       (cmd_op_i       ),
    .cmd_addr_i     (cmd_addr_i     ),
    .cmd_full_o     (cmd_full_o     ),
    .rsp_valid_o    (rsp_valid_o    ),
    .rsp_op_o       (rsp_op_o       ),
    .rsp_hit_o      (rsp_hit_o      ),
    .rsp_way_o      (rsp_way_o      ),
    .rsp_state_o    (rsp_state_o    ),
    .rsp_writeback_o(rsp_writeback_o),
    .rsp_wb_tag_o   (rsp_wb_tag_o   )
  );

  always #5 clk_i = ~clk_i;

  function automatic htu_tag_t pool_tag(input int i);
    return htu_tag_t'(32'h0ABC0 + 32'(i) * 32'h111);
  endfunction

  // Predicts one response and advances the reference bank
  function automatic exp_rsp_t predict(input htu_op_e op, input htu_tag_t tag, input logic half);
    exp_rsp_t r;
    int       hw;
    int       hs;
    int       oth;
    hw  = -1;
    hs  = half ? 1 : 0;
    oth = half ? 0 : 1;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (m_valid[i] && m_tag[i] == tag) begin
        hw = i;
      end
    end
    r.op     = op;
    r.hit    = (hw >= 0);
    r.way    = '0;
    r.state  = ST_INVALID;
    r.wb     = 1'b0;
    r.wb_tag = '0;
    if (hw >= 0) begin
      r.way = WAY_W'(hw);
      case (op)
        OP_READ: begin
          if (m_st[hw][hs] == ST_INVALID) begin
            m_st[hw][hs] = ST_CLEAN;
          end
        end
        OP_WRITE: m_st[hw][hs] = ST_DIRTY;
        OP_FLUSH: begin
          for (int h = 0; h < 2; h++) begin
            if (m_st[hw][h] == ST_DIRTY) begin
              m_st[hw][h] = ST_CLEAN;
            end
          end
        end
        default: begin
          m_valid[hw]  = 1'b0;
          m_st[hw][0] = ST_INVALID;
          m_st[hw][1] = ST_INVALID;
        end
      endcase
      r.state = m_st[hw][hs];
    end else if (op == OP_READ || op == OP_WRITE) begin
      // Miss allocates the round-robin victim
      r.way    = WAY_W'(m_rr);
      r.wb     = m_valid[m_rr] && (m_st[m_rr][0] == ST_DIRTY || m_st[m_rr][1] == ST_DIRTY);
      r.wb_tag = m_tag[m_rr];
      m_valid[m_rr]     = 1'b1;
      m_tag[m_rr]       = tag;
      m_st[m_rr][hs]  = (op == OP_WRITE) ? ST_DIRTY : ST_CLEAN;
      m_st[m_rr][oth] = ST_INVALID;
      r.state = m_st[m_rr][hs];
      m_rr    = (m_rr + 1) % NUM_WAYS;
    end
    return r;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_state(input string name, input htu_state_e got, input htu_state_e exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_tag(input string name, input htu_tag_t got, input htu_tag_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_op(input string name, input htu_op_e got, input htu_op_e exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_way(input string name, input logic [WAY_W-1:0] got,
                           input logic [WAY_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  // Compare process, one prediction per response pulse
  always @(negedge clk_i) begin
    if (!rst_i && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no command pending");
        test_errors++;
      end else begin
        cur_exp = exp_q.pop_front();
        check_op("rsp_op_o", rsp_op_o, cur_exp.op);
        check_bit("rsp_hit_o", rsp_hit_o, cur_exp.hit);
        check_way("rsp_way_o", rsp_way_o, cur_exp.way);
        check_state("rsp_state_o", rsp_state_o, cur_exp.state);
        check_bit("rsp_writeback_o", rsp_writeback_o, cur_exp.wb);
        if (cur_exp.wb) begin
          check_tag("rsp_wb_tag_o", rsp_wb_tag_o, cur_exp.wb_tag);
        end
      end
    end
  end

  task automatic apply_reset();
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    exp_q.delete();
    m_rr = 0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      m_valid[i]  = 1'b0;
      m_tag[i]    = '0;
      m_st[i][0] = ST_INVALID;
      m_st[i][1] = ST_INVALID;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("cmd_full_o", cmd_full_o, 1'b0);
  endtask

  // Strobes one command, holding off while the FIFO reports full
  task automatic send_cmd(input htu_op_e op, input htu_tag_t tag, input logic half);
    int         cnt;
    logic [8:0] low;
    @(negedge clk_i);
    cnt = 0;
    while (cmd_full_o && cnt < TIMEOUT) begin
      cmd_valid_i = 1'b0;
      full_seen++;
      @(negedge clk_i);
      cnt++;
    end
    if (cmd_full_o) begin
      $display("timeout waiting for cmd_full_o to drop");
      timed_out   = 1'b1;
      cmd_valid_i = 1'b0;
    end else begin
      low         = 9'($random(seed));
      cmd_valid_i = 1'b1;
      cmd_op_i    = op;
      cmd_addr_i  = {tag, half, low};
      exp_q.push_back(predict(op, tag, half));
    end
  endtask

  task automatic idle();
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic drain();
    int cnt;
    idle();
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("timeout waiting for %0d responses", exp_q.size());
      timed_out = 1'b1;
    end
    repeat (3) @(negedge clk_i);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (test_errors != 0) begin
      n_failed++;
    end
    total_errors += test_errors;
    $display("test %0d %s: %0d errors", n_tests, name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    cmd_valid_i  = 1'b0;
    cmd_op_i     = OP_READ;
    cmd_addr_i   = '0;
    seed         = 87;
    test_errors  = 0;
    total_errors = 0;
    n_checks     = 0;
    n_tests      = 0;
    n_failed     = 0;
    full_seen    = 0;
    timed_out    = 1'b0;

    apply_reset();
    send_cmd(OP_READ, pool_tag(0), 1'b0);
    send_cmd(OP_READ, pool_tag(0), 1'b0);
    drain();
    end_test("read miss then hit");

    send_cmd(OP_WRITE, pool_tag(0), 1'b1);
    send_cmd(OP_FLUSH, pool_tag(0), 1'b1);
    drain();
    end_test("write and flush hit");

    send_cmd(OP_INVALIDATE, pool_tag(0), 1'b0);
    send_cmd(OP_READ, pool_tag(0), 1'b0);
    send_cmd(OP_INVALIDATE, pool_tag(5), 1'b1);
    send_cmd(OP_FLUSH, pool_tag(4), 1'b0);
    drain();
    end_test("invalidate and absent tags");

    apply_reset();
    send_cmd(OP_WRITE, pool_tag(0), 1'b0);
    send_cmd(OP_READ, pool_tag(1), 1'b1);
    send_cmd(OP_WRITE, pool_tag(2), 1'b1);
    send_cmd(OP_READ, pool_tag(3), 1'b0);
    send_cmd(OP_READ, pool_tag(4), 1'b0);
    send_cmd(OP_READ, pool_tag(5), 1'b1);
    send_cmd(OP_WRITE, pool_tag(0), 1'b1);
    drain();
    end_test("round-robin eviction");

    full_seen = 0;
    for (int i = 0; i < 12; i++) begin
      send_cmd(htu_op_e'(2'(i)), pool_tag(i % POOL), 1'(i));
    end
    drain();
    if (full_seen == 0) begin
      $display("cmd_full_o never rose during the burst");
      test_errors++;
    end
    end_test("back-to-back burst");

    for (int i = 0; i < 300; i++) begin
      send_cmd(htu_op_e'(2'($random(seed))), pool_tag($unsigned($random(seed)) % POOL),
               1'($random(seed)));
      if (($random(seed) & 3) == 0) begin
        idle();
      end
    end
    drain();
    end_test("random mix");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
htu_pkg.sv
htu_req_if.sv
htu_offset.sv
htu_cacheline.sv
htu_set.sv
htu_cmd_decoder.sv
htu_req_fifo.sv
htu_top.sv
htu_checker.sv
htu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module htu_tb -f verilog.f -o htu_sim

./obj_dir/htu_sim 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
